//--- files.f
hw/cam_pkg.sv
hw/frame_capture.sv
hw/bayer_to_rgb.sv
hw/rgb_packer.sv
hw/pixel_fifo.sv
hw/frame_count_display.sv
hw/camera_pipeline_top.sv
tests/camera_pipeline_assertions.sv
tests/tb_camera_pipeline.sv

//--- Makefile
TOP = tb_camera_pipeline

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

//--- tests/tb_camera_pipeline.sv
/*
  Drives random 8x4 Bayer frames into the pipeline with a 4-entry FIFO.
  Expected words come from a demosaic and 5-5-5 model of each frame.
  Failures of the bound protocol assertions are counted at the end.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_camera_pipeline;
  import cam_pkg::*;

  localparam int IMG_WIDTH  = 8;
  localparam int IMG_HEIGHT = 4;
  localparam int FIFO_DEPTH = 4;
  localparam int WAIT_LIMIT = 200;                  // Cycles per wait
  localparam logic [6:0] SEG_ZERO  = 7'b1000000;    // Only g dark
  localparam logic [6:0] SEG_THREE = 7'b0110000;    // e and f dark
  localparam chan_enable_t ALL_ON   = '{red_en: 1'b1, green_en: 1'b1, blue_en: 1'b1};
  localparam chan_enable_t NO_GREEN = '{red_en: 1'b1, green_en: 1'b0, blue_en: 1'b1};

  logic                        ccd_pixel_clk;
  logic                        hps_fpga_reset_n;
  raw_t                        raw_data;
  cam_sync_t                   raw_sync;
  logic                        capture_start;
  chan_enable_t                chan_enable;
  logic                        pix_ready;
  rgb555_t                     pix_data;
  logic                        pix_valid;
  logic [FRAME_CNT_W-1:0]      frame_count;
  logic [DROP_CNT_W-1:0]       drop_count;
  logic [SEG_DIGITS-1:0][6:0]  hex_segments;

  raw_t    frame [IMG_HEIGHT][IMG_WIDTH];   // Current sensor frame
  rgb555_t model_words [$];                 // Model output of that frame
  rgb555_t expected [$];                    // Words still owed by the DUT
  rgb555_t head_word;
  int      errors;
  int      checks;
  int      tests;
  int      words_seen;
  int      test_start_errors;
  int      words_before;
  logic [DROP_CNT_W-1:0] drops_before;

  camera_pipeline_top #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .raw_data         (raw_data),
    .raw_sync         (raw_sync),
    .capture_start    (capture_start),
    .chan_enable      (chan_enable),
    .pix_ready        (pix_ready),
    .pix_data         (pix_data),
    .pix_valid        (pix_valid),
    .frame_count      (frame_count),
    .drop_count       (drop_count),
    .hex_segments     (hex_segments)
  );

  initial begin
    ccd_pixel_clk = 1'b0;
    forever #10 ccd_pixel_clk = ~ccd_pixel_clk;   // 20 ns period
  end

  // ==========================================================================
  // Checking helpers and model
  // ==========================================================================
  task automatic expect_eq(input string sig, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, sig, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name,
             (errors == test_start_errors) ? "passed" : "FAILED");
    test_start_errors = errors;
  endtask

  // Random frame plus one expected word per 2x2 quad
  task automatic gen_frame(input chan_enable_t en);
    logic [RAW_W:0] green_sum;
    raw_t           red;
    raw_t           green;
    raw_t           blue;
    rgb555_t        word;
    model_words.delete();
    for (int y = 0; y < IMG_HEIGHT; y++)
      for (int x = 0; x < IMG_WIDTH; x++) frame[y][x] = raw_t'($urandom);
    for (int y = 1; y < IMG_HEIGHT; y += 2) begin
      for (int x = 1; x < IMG_WIDTH; x += 2) begin
        red       = frame[y-1][x];                  // R on the even row
        blue      = frame[y][x-1];                  // B left on the odd row
        green_sum = {1'b0, frame[y-1][x-1]} + {1'b0, frame[y][x]};
        green     = green_sum[RAW_W:1];
        word.pad  = 1'b0;
        word.r    = en.red_en   ? red[RAW_W-1 -: CHAN5_W]   : '0;
        word.g    = en.green_en ? green[RAW_W-1 -: CHAN5_W] : '0;
        word.b    = en.blue_en  ? blue[RAW_W-1 -: CHAN5_W]  : '0;
        model_words.push_back(word);
      end
    end
  endtask

  // Sensor timing with line blanking
  task automatic drive_frame();
    repeat (3) @(posedge ccd_pixel_clk);
    raw_sync <= '{frame_valid: 1'b1, line_valid: 1'b0};
    repeat (2) @(posedge ccd_pixel_clk);
    for (int y = 0; y < IMG_HEIGHT; y++) begin
      for (int x = 0; x < IMG_WIDTH; x++) begin
        raw_sync <= '{frame_valid: 1'b1, line_valid: 1'b1};
        raw_data <= frame[y][x];
        @(posedge ccd_pixel_clk);
      end
      raw_sync <= '{frame_valid: 1'b1, line_valid: 1'b0};
      repeat (3) @(posedge ccd_pixel_clk);
    end
    raw_sync <= '0;
    raw_data <= '0;
    repeat (4) @(posedge ccd_pixel_clk);     // Frame end reaches the counter
  endtask

  task automatic wait_words_done(input string what);
    int cycles;
    cycles = 0;
    while (expected.size() != 0 && cycles < WAIT_LIMIT) begin
      @(posedge ccd_pixel_clk);
      cycles++;
    end
    if (expected.size() != 0) begin
      $display("Timeout: %0d words of the %s frame never came out", expected.size(), what);
      errors++;
      expected.delete();
    end
  endtask

  task automatic wait_drop_count(input logic [DROP_CNT_W-1:0] target);
    int cycles;
    cycles = 0;
    while (drop_count != target && cycles < WAIT_LIMIT) begin
      @(posedge ccd_pixel_clk);
      cycles++;
    end
    if (drop_count != target) begin
      $display("Timeout: drop_count stuck at %0d, waiting for %0d", drop_count, target);
      errors++;
    end
  endtask

  // Every transfer is checked against the head of the expected queue
  always @(negedge ccd_pixel_clk) begin
    if (hps_fpga_reset_n && pix_valid && pix_ready) begin
      words_seen++;
      if (expected.size() == 0) begin
        $display("Unexpected word 0x%0h read at %0t ns", pix_data, $time);
        errors++;
      end else begin
        head_word = expected.pop_front();
        expect_eq("pix_data", head_word, pix_data);
        if (!chan_enable.green_en) expect_eq("pix_data.g", 0, pix_data.g);
      end
    end
  end

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    void'($urandom(45603));
    errors            = 0;
    checks            = 0;
    tests             = 0;
    words_seen        = 0;
    test_start_errors = 0;
    hps_fpga_reset_n  = 1'b0;
    raw_data          = '0;
    raw_sync          = '0;
    capture_start     = 1'b0;
    chan_enable       = ALL_ON;
    pix_ready         = 1'b1;
    repeat (2) @(posedge ccd_pixel_clk);
    hps_fpga_reset_n <= 1'b1;

    @(negedge ccd_pixel_clk);
    expect_eq("pix_valid", 0, pix_valid);
    expect_eq("frame_count", 0, frame_count);
    expect_eq("drop_count", 0, drop_count);
    end_test("reset values");

    // Frame sent with start low is ignored
    words_before = words_seen;
    gen_frame(chan_enable);
    drive_frame();
    repeat (10) @(posedge ccd_pixel_clk);
    @(negedge ccd_pixel_clk);
    expect_eq("words read", words_before, words_seen);
    expect_eq("frame_count", 0, frame_count);
    @(posedge ccd_pixel_clk);
    capture_start <= 1'b1;
    gen_frame(chan_enable);
    foreach (model_words[i]) expected.push_back(model_words[i]);
    drive_frame();
    wait_words_done("start control");
    expect_eq("frame_count", 1, frame_count);
    end_test("start control");

    gen_frame(chan_enable);
    foreach (model_words[i]) expected.push_back(model_words[i]);
    drive_frame();
    wait_words_done("demosaic");
    expect_eq("frame_count", 2, frame_count);
    expect_eq("drop_count", 0, drop_count);
    end_test("demosaic and pack");

    chan_enable <= NO_GREEN;
    gen_frame(NO_GREEN);
    foreach (model_words[i]) expected.push_back(model_words[i]);
    drive_frame();
    wait_words_done("channel enable");
    expect_eq("frame_count", 3, frame_count);
    chan_enable <= ALL_ON;
    end_test("channel enables");

    @(negedge ccd_pixel_clk);
    for (int d = 0; d < SEG_DIGITS; d++)
      expect_eq($sformatf("hex_segments[%0d]", d), (d == 0) ? SEG_THREE : SEG_ZERO,
                hex_segments[d]);
    end_test("display");

    // Reader stalled for a whole frame so the FIFO fills and the rest is dropped
    @(posedge ccd_pixel_clk);
    drops_before = drop_count;
    pix_ready   <= 1'b0;
    gen_frame(chan_enable);
    drive_frame();
    wait_drop_count(DROP_CNT_W'(drops_before + FIFO_DEPTH));
    for (int i = 0; i < FIFO_DEPTH; i++) expected.push_back(model_words[i]);
    @(negedge ccd_pixel_clk);
    expect_eq("pix_valid", 1, pix_valid);
    @(posedge ccd_pixel_clk);
    pix_ready <= 1'b1;
    wait_words_done("back-pressure");
    expect_eq("drop_count", drops_before + FIFO_DEPTH, drop_count);
    expect_eq("frame_count", 4, frame_count);
    end_test("back-pressure");

    if (u_dut.u_pixel_fifo.u_fifo_checks.violations != 0 ||
        u_dut.u_rgb_packer.u_credit_checks.violations != 0) begin
      $display("Bound protocol assertions failed during the run");
      errors++;
    end
    $display("%0d tests, %0d checks, %0d failures", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/camera_pipeline_assertions.sv
/*
  Protocol checks bound into pixel_fifo and into rgb_packer.
  count is the FIFO fill level or the packer credit count.
  Inputs that a binding does not use are tied low.
*/
`timescale 1ns/1ps
`default_nettype none

module camera_pipeline_assertions #(
  parameter int FIFO_DEPTH = 128,
  parameter bit FIFO_PORT  = 1'b1                 // Low when bound to the packer
) (
  input  wire                                ccd_pixel_clk,
  input  wire                                hps_fpga_reset_n,
  input  wire [$clog2(FIFO_DEPTH + 1)-1:0]   count,
  input  wire                                push,
  input  wire                                pix_valid,
  input  wire                                pix_ready,
  input  cam_pkg::rgb555_t                   pix_data
);
  import cam_pkg::*;

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  int unsigned violations = 0;   // Read by the testbench at the end

  // ==========================================================================
  // Credit and FIFO protocol
  // ==========================================================================
  count_in_range: assert property (
    @(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
    count <= CNT_W'(FIFO_DEPTH)          // Credits or fill level
  ) else begin
    $error("count %0d above FIFO_DEPTH", count);
    violations = violations + 1;
  end

  // Push and head checks need the FIFO side of the link
  if (FIFO_PORT) begin : g_fifo_port
    // A push into a full FIFO would overwrite the head entry
    no_push_when_full: assert property (
      @(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
      push |-> (count != CNT_W'(FIFO_DEPTH))
    ) else begin
      $error("push while the FIFO holds %0d entries", FIFO_DEPTH);
      violations = violations + 1;
    end

    // Head word held while the reader stalls
    head_stable: assert property (
      @(posedge ccd_pixel_clk) disable iff (!hps_fpga_reset_n)
      (pix_valid && !pix_ready) |=> $stable(pix_data)
    ) else begin
      $error("pix_data changed while stalled");
      violations = violations + 1;
    end
  end

endmodule

bind pixel_fifo camera_pipeline_assertions #(
  .FIFO_DEPTH (FIFO_DEPTH),
  .FIFO_PORT  (1'b1)
) u_fifo_checks (
  .ccd_pixel_clk    (ccd_pixel_clk),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .count            (fill_count),
  .push             (push),
  .pix_valid        (pix_valid),
  .pix_ready        (pix_ready),
  .pix_data         (pix_data)
);

bind rgb_packer camera_pipeline_assertions #(
  .FIFO_DEPTH (FIFO_DEPTH),
  .FIFO_PORT  (1'b0)
) u_credit_checks (
  .ccd_pixel_clk    (ccd_pixel_clk),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .count            (credits),
  .push             (1'b0),
  .pix_valid        (1'b0),
  .pix_ready        (1'b0),
  .pix_data         (push_data)
);

`default_nettype wire

//--- hw/camera_pipeline_top.sv
/*
  Camera path in one clock domain: capture, demosaic, pack, FIFO.
  A word moves on pix_valid and pix_ready; pixels beyond FIFO_DEPTH are dropped.
*/
`timescale 1ns/1ps
`default_nettype none

module camera_pipeline_top #(
  parameter int IMG_WIDTH  = 1280,
  parameter int IMG_HEIGHT = 960,
  parameter int FIFO_DEPTH = 128
) (
  input  wire                                  ccd_pixel_clk,
  input  wire                                  hps_fpga_reset_n,
  input  cam_pkg::raw_t                        raw_data,
  input  cam_pkg::cam_sync_t                   raw_sync,
  input  wire                                  capture_start,  // Level
  input  cam_pkg::chan_enable_t                chan_enable,
  input  wire                                  pix_ready,
  output cam_pkg::rgb555_t                     pix_data,
  output logic                                 pix_valid,
  output logic [cam_pkg::FRAME_CNT_W-1:0]      frame_count,
  output logic [cam_pkg::DROP_CNT_W-1:0]       drop_count,
  output logic [cam_pkg::SEG_DIGITS-1:0][6:0]  hex_segments
);
  import cam_pkg::*;

  // ==========================================================================
  // Stage wires
  // ==========================================================================
  raw_t               cap_sample;
  logic               cap_valid;
  logic [COORD_W-1:0] cap_x;
  logic [COORD_W-1:0] cap_y;
  rgb_sample_t        rgb;
  logic               rgb_valid;
  logic               push;
  rgb555_t            push_data;
  logic               credit_return;

  frame_capture #(
    .IMG_WIDTH  (IMG_WIDTH),
    .IMG_HEIGHT (IMG_HEIGHT)
  ) u_frame_capture (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .raw_data         (raw_data),
    .raw_sync         (raw_sync),
    .capture_start    (capture_start),
    .cap_sample       (cap_sample),
    .cap_valid        (cap_valid),
    .cap_x            (cap_x),
    .cap_y            (cap_y),
    .frame_count      (frame_count)
  );

  bayer_to_rgb #(
    .IMG_WIDTH (IMG_WIDTH)
  ) u_bayer_to_rgb (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .cap_sample       (cap_sample),
    .cap_valid        (cap_valid),
    .cap_x            (cap_x),
    .cap_y            (cap_y),
    .rgb              (rgb),
    .rgb_valid        (rgb_valid)
  );

  rgb_packer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_rgb_packer (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .rgb              (rgb),
    .rgb_valid        (rgb_valid),
    .chan_enable      (chan_enable),
    .credit_return    (credit_return),
    .push             (push),
    .push_data        (push_data),
    .drop_count       (drop_count)
  );

  pixel_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_pixel_fifo (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .push             (push),
    .push_data        (push_data),
    .pix_ready        (pix_ready),
    .pix_data         (pix_data),
    .pix_valid        (pix_valid),
    .credit_return    (credit_return)
  );

  frame_count_display u_frame_count_display (
    .ccd_pixel_clk    (ccd_pixel_clk),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .frame_count      (frame_count),
    .hex_segments     (hex_segments)
  );

endmodule

`default_nettype wire

//--- hw/frame_count_display.sv
/*
  Shows the low 24 bits of the frame count as six hex digits, one cycle late.
  Segments a..g on bits 0..6, active low; all segments off during reset.
*/
`timescale 1ns/1ps
`default_nettype none

module frame_count_display (
  input  wire                                  ccd_pixel_clk,
  input  wire                                  hps_fpga_reset_n,
  input  wire [cam_pkg::FRAME_CNT_W-1:0]       frame_count,
  output logic [cam_pkg::SEG_DIGITS-1:0][6:0]  hex_segments
);
  import cam_pkg::*;

  // Hex nibble to segment code
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
    logic [6:0] seg;
    case (nibble)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'ha: seg = 7'h08;
      4'hb: seg = 7'h03;   // Lower case b
      4'hc: seg = 7'h46;
      4'hd: seg = 7'h21;   // Lower case d
      4'he: seg = 7'h06;
      default: seg = 7'h0e;
    endcase
    return seg;
  endfunction

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      hex_segments <= '1;                     // Blank
    end else begin
      for (int d = 0; d < SEG_DIGITS; d++) begin
        hex_segments[d] <= hex_to_seg(frame_count[4*d +: 4]);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/pixel_fifo.sv
/*
  Show-ahead circular buffer; the head word is on pix_data whenever pix_valid.
  No full check here, the packer's credits keep pushes off a full FIFO.
  Every pop returns one credit on the following cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
  parameter int FIFO_DEPTH = 128
) (
  input  wire                  ccd_pixel_clk,
  input  wire                  hps_fpga_reset_n,
  input  wire                  push,
  input  cam_pkg::rgb555_t     push_data,
  input  wire                  pix_ready,
  output cam_pkg::rgb555_t     pix_data,
  output logic                 pix_valid,
  output logic                 credit_return
);
  import cam_pkg::*;

  localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);

  rgb555_t           mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [CNT_W-1:0]  fill_count;     // Entries held
  logic              pop;

  // Head entry straight from the array
  assign pix_data  = mem[rd_ptr];
  assign pix_valid = (fill_count != '0);
  assign pop       = pix_valid & pix_ready;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [ADDR_W-1:0] ptr_next(input logic [ADDR_W-1:0] ptr);
    return (ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge ccd_pixel_clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill_count    <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;                   // One credit per pop
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop)  rd_ptr <= ptr_next(rd_ptr);
      case ({push, pop})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/rgb_packer.sv
/*
  Keeps the top 5 bits of each colour; a disabled channel reads as zero.
  Pushes only while a FIFO credit is held, otherwise the pixel is dropped
  and counted. The drop counter saturates and clears only on reset.
*/
`timescale 1ns/1ps
`default_nettype none

module rgb_packer #(
  parameter int FIFO_DEPTH = 128
) (
  input  wire                              ccd_pixel_clk,
  input  wire                              hps_fpga_reset_n,
  input  cam_pkg::rgb_sample_t             rgb,
  input  wire                              rgb_valid,
  input  cam_pkg::chan_enable_t            chan_enable,
  input  wire                              credit_return,
  output logic                             push,
  output cam_pkg::rgb555_t                 push_data,
  output logic [cam_pkg::DROP_CNT_W-1:0]   drop_count
);
  import cam_pkg::*;

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  logic [CRED_W-1:0] credits;
  logic              has_credit;
  logic              spend;
  rgb555_t           packed_word;

  assign has_credit = (credits != '0);
  assign spend      = rgb_valid & has_credit;

  // Truncate and mask
  always_comb begin
    packed_word.pad = 1'b0;
    packed_word.r   = chan_enable.red_en   ? rgb.red[RAW_W-1 -: CHAN5_W]   : '0;
    packed_word.g   = chan_enable.green_en ? rgb.green[RAW_W-1 -: CHAN5_W] : '0;
    packed_word.b   = chan_enable.blue_en  ? rgb.blue[RAW_W-1 -: CHAN5_W]  : '0;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (spend) push_data <= packed_word;
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      credits    <= CRED_W'(FIFO_DEPTH);       // FIFO starts empty
      push       <= 1'b0;
      drop_count <= '0;
    end else begin
      push <= spend;
      case ({spend, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;           // Both or neither cancel out
      endcase
      if (rgb_valid && !has_credit && drop_count != {DROP_CNT_W{1'b1}}) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/bayer_to_rgb.sv
/*
  2x2 Bayer quad to one RGB pixel, so output is half width and half height.
  Mosaic: even rows G R G R, odd rows B G B G. Only even rows are stored.
  Green is the mean of the two greens, truncated.
*/
`timescale 1ns/1ps
`default_nettype none

module bayer_to_rgb #(
  parameter int IMG_WIDTH = 1280
) (
  input  wire                          ccd_pixel_clk,
  input  wire                          hps_fpga_reset_n,
  input  cam_pkg::raw_t                cap_sample,
  input  wire                          cap_valid,
  input  wire [cam_pkg::COORD_W-1:0]   cap_x,
  input  wire [cam_pkg::COORD_W-1:0]   cap_y,
  output cam_pkg::rgb_sample_t         rgb,
  output logic                         rgb_valid
);
  import cam_pkg::*;

  localparam int ADDR_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1;

  raw_t              line_buf [IMG_WIDTH];   // Previous even row
  raw_t              prev_sample;            // Left neighbour, current row
  raw_t              above_prev;             // Above-left neighbour
  raw_t              above;
  logic [ADDR_W-1:0] addr;
  logic              odd_row;
  logic              odd_col;
  logic              emit;
  logic [RAW_W:0]    green_sum;              // One extra bit for the carry

  assign addr    = cap_x[ADDR_W-1:0];
  assign odd_row = cap_y[0];
  assign odd_col = cap_x[0];
  assign above   = line_buf[addr];
  assign emit    = cap_valid & odd_row & odd_col;

  // Above-left green plus current green
  assign green_sum = {1'b0, above_prev} + {1'b0, cap_sample};

  // ==========================================================================
  // Line buffer and neighbour registers
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (cap_valid && !odd_row) begin
      line_buf[addr] <= cap_sample;          // Store G/R row
    end
    if (cap_valid) begin
      prev_sample <= cap_sample;
    end
    if (cap_valid && odd_row) begin
      above_prev <= above;                   // Becomes above-left next sample
    end
  end

  // ==========================================================================
  // Pixel output, one cycle after the odd/odd sample
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (emit) begin
      rgb.red   <= above;                    // R sits above on even row
      rgb.green <= green_sum[RAW_W:1];
      rgb.blue  <= prev_sample;              // B to the left on odd row
    end
  end

  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      rgb_valid <= 1'b0;
    end else begin
      rgb_valid <= emit;
    end
  end

endmodule

`default_nettype wire

//--- hw/frame_capture.sv
/*
  Pins are registered once, then captured; data is valid 2 cycles after the pins.
  A line is taken to end after IMG_WIDTH valid samples; counters also clear
  at every frame_valid fall. Start is sampled only at frame edges.
*/
`timescale 1ns/1ps
`default_nettype none

module frame_capture #(
  parameter int IMG_WIDTH  = 1280,
  parameter int IMG_HEIGHT = 960
) (
  input  wire                              ccd_pixel_clk,
  input  wire                              hps_fpga_reset_n,
  input  cam_pkg::raw_t                    raw_data,
  input  cam_pkg::cam_sync_t               raw_sync,
  input  wire                              capture_start,
  output cam_pkg::raw_t                    cap_sample,
  output logic                             cap_valid,
  output logic [cam_pkg::COORD_W-1:0]      cap_x,
  output logic [cam_pkg::COORD_W-1:0]      cap_y,
  output logic [cam_pkg::FRAME_CNT_W-1:0]  frame_count
);
  import cam_pkg::*;

  raw_t                raw_q;       // Pin register, data
  cam_sync_t           sync_q;      // Pin register, sync
  logic                fval_d;      // Previous frame_valid for edges
  logic                active;
  logic                active_now;
  logic                fval_rise;
  logic                fval_fall;
  logic                sample_ok;
  logic [COORD_W-1:0]  x_cnt;
  logic [COORD_W-1:0]  y_cnt;

  assign fval_rise = sync_q.frame_valid & ~fval_d;
  assign fval_fall = ~sync_q.frame_valid & fval_d;

  // Start arms on a frame rise, stop takes effect on a frame fall
  always_comb begin
    active_now = active;
    if (!active && fval_rise && capture_start) active_now = 1'b1;
    if (active && fval_fall && !capture_start) active_now = 1'b0;
  end

  assign sample_ok = active_now & sync_q.frame_valid & sync_q.line_valid;

  // ==========================================================================
  // Data path registers
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    raw_q      <= raw_data;
    cap_sample <= raw_q;
  end

  // ==========================================================================
  // Control and counters
  // ==========================================================================
  always_ff @(posedge ccd_pixel_clk) begin
    if (!hps_fpga_reset_n) begin
      sync_q      <= '0;
      fval_d      <= 1'b0;
      active      <= 1'b0;
      cap_valid   <= 1'b0;
      cap_x       <= '0;
      cap_y       <= '0;
      x_cnt       <= '0;
      y_cnt       <= '0;
      frame_count <= '0;
    end else begin
      sync_q    <= raw_sync;
      fval_d    <= sync_q.frame_valid;
      active    <= active_now;
      cap_valid <= sample_ok;
      if (sample_ok) begin
        cap_x <= x_cnt;                 // Coordinates travel with the sample
        cap_y <= y_cnt;
        if (x_cnt == COORD_W'(IMG_WIDTH - 1)) begin
          x_cnt <= '0;                  // End of line
          y_cnt <= (y_cnt == COORD_W'(IMG_HEIGHT - 1)) ? '0 : y_cnt + 1'b1;
        end else begin
          x_cnt <= x_cnt + 1'b1;
        end
      end else if (fval_fall) begin
        x_cnt <= '0;                    // End of frame, resync
        y_cnt <= '0;
        if (active) frame_count <= frame_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/cam_pkg.sv
/*
  Shared widths and types for the single-clock camera data path.
  Sample width follows a 12-bit Bayer sensor; the packed word is 5-5-5
  with a zero pad bit on top, as the downstream reader expects.
*/
`default_nettype none

package cam_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================
  localparam int RAW_W       = 12;  // Camera sample
  localparam int COORD_W     = 12;  // Column and row counters
  localparam int CHAN5_W     = 5;   // Bits kept per colour
  localparam int SEG_DIGITS  = 6;   // Seven-segment digits
  localparam int FRAME_CNT_W = 32;
  localparam int DROP_CNT_W  = 16;  // Saturating drop counter

  // ==========================================================================
  // Types
  // ==========================================================================
  typedef logic [RAW_W-1:0] raw_t;

  // Sensor sync pins, registered together with the data
  typedef struct packed {
    logic frame_valid;
    logic line_valid;
  } cam_sync_t;

  // Full-precision demosaic output
  typedef struct packed {
    raw_t red;
    raw_t green;
    raw_t blue;
  } rgb_sample_t;

  // FIFO word, bit 15 always zero
  typedef struct packed {
    logic               pad;
    logic [CHAN5_W-1:0] r;
    logic [CHAN5_W-1:0] g;
    logic [CHAN5_W-1:0] b;
  } rgb555_t;

  typedef struct packed {
    logic red_en;
    logic green_en;
    logic blue_en;
  } chan_enable_t;

endpackage

`default_nettype wire
